// File: list.f
rtl/pll_reconfig_pkg.sv
rtl/pll_reconfig_regs.sv
rtl/pll_reconfig_map.sv
rtl/pll_reconfig_rmw.sv
rtl/pll_reconfig_fsm.sv
rtl/pll_reconfig_ctrl.sv
tests/basic_block_model.sv
tests/pll_reconfig_asserts.sv
tests/pll_reconfig_tb.sv

// File: rtl/pll_reconfig_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pll_reconfig_ctrl import pll_reconfig_pkg::*; (
  input  wire                     clk,
  input  wire                     reset,
  // User port
  input  wire                     uif_go,
  input  wire [2:0]               uif_mode,
  input  wire [UIF_ADDR_W-1:0]    uif_addr,
  input  wire [UIF_DATA_W-1:0]    uif_wdata,
  input  wire [LCH_W-1:0]         uif_logical_ch_addr,
  output logic [UIF_DATA_W-1:0]   uif_rdata,
  output logic                    uif_busy,
  output logic                    uif_addr_err,
  // Basic block port
  output logic                    ctrl_go,
  output logic [2:0]              ctrl_opcode,
  output logic                    ctrl_lock,
  input  wire                     ctrl_wait,
  output logic [LCH_W-1:0]        ctrl_lch,
  output logic [CTRL_ADDR_W-1:0]  ctrl_addr,
  input  wire [CTRL_DATA_W-1:0]   ctrl_rdata,
  output logic [CTRL_DATA_W-1:0]  ctrl_wdata
);

  logic                              start;
  logic                              l2p_read;
  switch_kind_t                      kind;
  logic [2:0]                        logical_index;
  logic [NUM_LOGICAL*REFCLK_ID_W-1:0] phys_refclk_word;
  logic [NUM_LOGICAL*CGB_ID_W-1:0]   phys_cgb_word;
  logic [9:0]                        cgb_bits;
  logic [9:0]                        cdr_bits;
  logic [15:0]                       merge_data;
  logic [CTRL_ADDR_W-1:0]            word_addr;
  logic                              rom_load;
  logic                              capture;
  logic [1:0]                        word_cnt;

  assign ctrl_lch = uif_logical_ch_addr;  // Single requester

  pll_reconfig_regs pll_reconfig_regs_inst (
    .clk, .reset, .uif_go, .uif_mode, .uif_addr, .uif_wdata,
    .phys_refclk_word, .phys_cgb_word, .uif_rdata, .uif_addr_err,
    .start, .l2p_read, .kind, .logical_index
  );

  pll_reconfig_map pll_reconfig_map_inst (
    .clk, .reset, .kind, .logical_index, .rom_load, .ctrl_rdata,
    .phys_refclk_word, .phys_cgb_word, .cgb_bits, .cdr_bits
  );

  pll_reconfig_rmw pll_reconfig_rmw_inst (
    .clk, .reset, .kind, .word_cnt, .capture, .ctrl_rdata,
    .cgb_bits, .cdr_bits, .merge_data, .word_addr
  );

  // Sequencer, owns the basic block handshake
  pll_reconfig_fsm pll_reconfig_fsm_inst (
    .clk, .reset, .start, .l2p_read, .kind, .ctrl_wait, .merge_data, .word_addr,
    .uif_busy, .ctrl_go, .ctrl_opcode, .ctrl_lock, .ctrl_addr, .ctrl_wdata,
    .rom_load, .capture, .word_cnt
  );

endmodule

`default_nettype wire

// File: rtl/pll_reconfig_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module pll_reconfig_fsm import pll_reconfig_pkg::*; (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     start,
  input  wire                     l2p_read,
  input  var switch_kind_t        kind,
  input  wire                     ctrl_wait,
  input  wire [15:0]              merge_data,
  input  wire [CTRL_ADDR_W-1:0]   word_addr,
  output logic                    uif_busy,
  output logic                    ctrl_go,
  output logic [2:0]              ctrl_opcode,
  output logic                    ctrl_lock,
  output logic [CTRL_ADDR_W-1:0]  ctrl_addr,
  output logic [CTRL_DATA_W-1:0]  ctrl_wdata,
  output logic                    rom_load,
  output logic                    capture,
  output logic [1:0]              word_cnt
);

  pll_state_t state;
  pll_state_t next_state;
  logic [2:0] ev_cnt;      // Steps done in this RMW word
  logic       l2p_active;  // ROM fetch only

  //////////////////////////////
  // State machine
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      state <= IDLE;
    else
      state <= next_state;
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE:           if (start || l2p_read) next_state = RD_L2P;
      RD_L2P, RD, WR: next_state = WAIT;
      WAIT:           next_state = DECIDE;
      DECIDE: begin
        if (!ctrl_wait) begin  // Basic block done
          if (l2p_active)
            next_state = IDLE;
          else if (ev_cnt == 3'd1)
            next_state = RD;
          else if (ev_cnt == 3'd2)
            next_state = WR;
          else if (ev_cnt == 3'd3)
            next_state = CHK_WORDS;
        end
      end
      CHK_WORDS:      next_state = (word_cnt == 2'd0) ? IDLE : WAIT;
      default:        next_state = IDLE;
    endcase
  end

  // Counters and request flag
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ev_cnt     <= 3'd0;
      word_cnt   <= 2'd0;
      l2p_active <= 1'b0;
    end else begin
      if (state == IDLE)
        l2p_active <= l2p_read;
      if (state == IDLE || (state == DECIDE && next_state == CHK_WORDS))
        ev_cnt <= 3'd0;
      else if (next_state == DECIDE && state != DECIDE)
        ev_cnt <= ev_cnt + 3'd1;
      if (state == RD_L2P)
        word_cnt <= (kind == SW_CGB) ? 2'd0 : 2'd2;  // One CGB word, three refclk words
      else if (state == CHK_WORDS && word_cnt != 2'd0)
        word_cnt <= word_cnt - 2'd1;
    end
  end

  // Read data strobes
  assign rom_load = (state == DECIDE) && !ctrl_wait && (ctrl_opcode == CTRL_OP_ROM_RD);
  assign capture  = (state == DECIDE) && !ctrl_wait && (ctrl_opcode == CTRL_OP_RD);

  //////////////////////////////
  // Registered outputs
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      uif_busy    <= 1'b0;
      ctrl_go     <= 1'b0;
      ctrl_lock   <= 1'b0;
      ctrl_opcode <= 3'd0;
      ctrl_addr   <= '0;
      ctrl_wdata  <= '0;
    end else begin
      uif_busy  <= (next_state != IDLE);
      ctrl_go   <= (state inside {RD_L2P, RD, WR});  // One pulse per access
      ctrl_lock <= (state != IDLE) && (ev_cnt < 3'd3) && !l2p_active;
      if (next_state == IDLE)
        ctrl_opcode <= 3'd0;
      else if (state == RD_L2P)
        ctrl_opcode <= CTRL_OP_ROM_RD;
      else if (state == RD)
        ctrl_opcode <= CTRL_OP_RD;
      else if (state == WR)
        ctrl_opcode <= CTRL_OP_WR;
      if (state == IDLE)
        ctrl_addr <= '0;
      else if (state == RD_L2P)
        ctrl_addr <= (kind == SW_CGB) ? ROM_WORD_CGB : ROM_WORD_RC;
      else if (state == RD || state == WR)
        ctrl_addr <= word_addr;
      if (state == IDLE)
        ctrl_wdata <= '0;
      else if (state == WR)
        ctrl_wdata <= CTRL_DATA_W'(merge_data);  // Merged word back to DPRIO
    end
  end

endmodule

`default_nettype wire

// File: rtl/pll_reconfig_map.sv
`timescale 1ns/1ps
`default_nettype none

module pll_reconfig_map import pll_reconfig_pkg::*; (
  input  wire                                 clk,
  input  wire                                 reset,
  input  var switch_kind_t                    kind,
  input  wire [2:0]                           logical_index,
  input  wire                                 rom_load,
  input  wire [CTRL_DATA_W-1:0]               ctrl_rdata,
  output logic [NUM_LOGICAL*REFCLK_ID_W-1:0]  phys_refclk_word,
  output logic [NUM_LOGICAL*CGB_ID_W-1:0]     phys_cgb_word,
  output logic [9:0]                          cgb_bits,  // {x_en, clk_sel}
  output logic [9:0]                          cdr_bits   // {rrefclk_sel, pcie_mode, iq_clk_sel}
);

  logic [CGB_ID_W-1:0]    cgb_id;
  logic [REFCLK_ID_W-1:0] rc_id;

  // L2P words, one per switch kind
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      phys_refclk_word <= '0;
      phys_cgb_word    <= '0;
    end else if (rom_load) begin
      if (kind == SW_CGB)
        phys_cgb_word <= ctrl_rdata[NUM_LOGICAL*CGB_ID_W-1:0];
      else
        phys_refclk_word <= ctrl_rdata[NUM_LOGICAL*REFCLK_ID_W-1:0];
    end
  end

  // Pick physical ID for the logical index
  always_comb begin
    if (logical_index < 3'(NUM_LOGICAL)) begin
      cgb_id = phys_cgb_word[logical_index*CGB_ID_W +: CGB_ID_W];
      rc_id  = phys_refclk_word[logical_index*REFCLK_ID_W +: REFCLK_ID_W];
    end else begin
      // Indices 5 to 7 fall back to slot 0
      cgb_id = phys_cgb_word[CGB_ID_W-1:0];
      rc_id  = phys_refclk_word[REFCLK_ID_W-1:0];
    end
  end

  //////////////////////////////
  // CGB remap, x_en and clk_sel
  always_comb begin
    case (cgb_id)
      4'd0:    cgb_bits = {2'b00, 8'b01_01_11_00}; // Same channel TX PLL
      4'd1:    cgb_bits = {2'b00, 8'b00_00_00_11}; // X1 top
      4'd2:    cgb_bits = {2'b00, 8'b01_01_00_00}; // X1 bottom
      4'd3:    cgb_bits = {2'b00, 8'b10_10_00_00}; // LC top
      4'd4:    cgb_bits = {2'b00, 8'b11_11_00_00}; // LC bottom
      4'd5:    cgb_bits = {2'b00, 8'b00_00_00_10}; // Fractional PLL
      4'd6:    cgb_bits = {2'b10, 8'b00_01_10_00}; // X6 up
      4'd7:    cgb_bits = {2'b01, 8'b00_01_01_00}; // X6 down
      4'd8:    cgb_bits = {2'b00, 8'b00_01_01_00}; // XN up
      4'd9:    cgb_bits = {2'b00, 8'b00_01_10_00}; // XN down
      default: cgb_bits = {2'b00, 8'b01_01_11_00}; // Bad ID, back to local PLL
    endcase
  end

  //////////////////////////////
  // CDR refclk remap
  always_comb begin
    case (rc_id) inside
      // REF_IQCLK0..10 count up from 1 in the low nibble
      [5'd0:5'd10]:  cdr_bits = {2'b00, 8'(rc_id) + 8'd1};
      // RX_IQCLK0..10 use the high nibble
      [5'd11:5'd21]: cdr_bits = {2'b00, 4'(rc_id - 5'd10), 4'b0000};
      5'd22:         cdr_bits = {2'b10, 8'h00};  // PLD clock
      5'd23:         cdr_bits = {2'b00, 8'h00};  // Cal clock
      5'd24:         cdr_bits = {2'b00, 8'h0C};  // FFPLL top
      5'd25:         cdr_bits = {2'b00, 8'h00};  // FFPLL bottom
      default:       cdr_bits = {2'b00, 8'h01};  // REF_IQCLK0
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/pll_reconfig_pkg.sv
`default_nettype none

package pll_reconfig_pkg;

  //////////////////////////////
  // Widths

  localparam int UIF_ADDR_W  = 3;   // User offset
  localparam int UIF_DATA_W  = 32;
  localparam int CTRL_ADDR_W = 12;  // Basic block address
  localparam int CTRL_DATA_W = 32;
  localparam int LCH_W       = 10;  // Logical channel

  localparam int REFCLK_ID_W = 5;   // Physical refclk ID
  localparam int CGB_ID_W    = 4;   // Physical CGB ID
  localparam int NUM_LOGICAL = 5;   // IDs packed per ROM word

  //////////////////////////////
  // Opcodes and offsets

  localparam logic [2:0] UIF_MODE_RD    = 3'b000;
  localparam logic [2:0] UIF_MODE_WR    = 3'b001;

  localparam logic [2:0] CTRL_OP_RD     = 3'd0; // DPRIO read, logical channel
  localparam logic [2:0] CTRL_OP_WR     = 3'd1; // DPRIO write
  localparam logic [2:0] CTRL_OP_ROM_RD = 3'd4; // L2P ROM fetch

  localparam logic [UIF_ADDR_W-1:0] UIF_OFS_RC_SEL   = 3'd0;
  localparam logic [UIF_ADDR_W-1:0] UIF_OFS_CGB_SEL  = 3'd1;
  localparam logic [UIF_ADDR_W-1:0] UIF_OFS_RC_PHYS  = 3'd2; // Read only
  localparam logic [UIF_ADDR_W-1:0] UIF_OFS_CGB_PHYS = 3'd3; // Read only
  localparam logic [UIF_ADDR_W-1:0] UIF_OFS_LAST     = 3'd3;

  localparam logic [CTRL_ADDR_W-1:0] ROM_WORD_RC      = 12'd1;
  localparam logic [CTRL_ADDR_W-1:0] ROM_WORD_CGB     = 12'd2;

  // DPRIO words touched by a switch
  localparam logic [CTRL_ADDR_W-1:0] DPRIO_CGB_OFS    = 12'h04A;
  localparam logic [CTRL_ADDR_W-1:0] DPRIO_REFIQ_OFS  = 12'h03A;
  localparam logic [CTRL_ADDR_W-1:0] DPRIO_RREF_OFS   = 12'h017;
  localparam logic [CTRL_ADDR_W-1:0] DPRIO_PCIEMD_OFS = 12'h010;

  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    RD_L2P    = 3'd1, // ROM read of the L2P word
    RD        = 3'd2, // DPRIO read
    WR        = 3'd3, // DPRIO write
    DECIDE    = 3'd4, // Wait out ctrl_wait, pick next step
    WAIT      = 3'd5, // Gives ctrl_wait a cycle to rise
    CHK_WORDS = 3'd6  // Any RMW words left
  } pll_state_t;

  typedef enum logic {
    SW_REFCLK = 1'b0,
    SW_CGB    = 1'b1
  } switch_kind_t;

endpackage

`default_nettype wire

// File: rtl/pll_reconfig_regs.sv
`timescale 1ns/1ps
`default_nettype none

module pll_reconfig_regs import pll_reconfig_pkg::*; (
  input  wire                                  clk,
  input  wire                                  reset,
  input  wire                                  uif_go,
  input  wire [2:0]                            uif_mode,
  input  wire [UIF_ADDR_W-1:0]                 uif_addr,
  input  wire [UIF_DATA_W-1:0]                 uif_wdata,
  input  wire [NUM_LOGICAL*REFCLK_ID_W-1:0]    phys_refclk_word,
  input  wire [NUM_LOGICAL*CGB_ID_W-1:0]       phys_cgb_word,
  output logic [UIF_DATA_W-1:0]                uif_rdata,
  output logic                                 uif_addr_err,
  output logic                                 start,
  output logic                                 l2p_read,
  output switch_kind_t                         kind,
  output logic [2:0]                           logical_index
);

  logic [2:0] rc_sel;   // Logical refclk select
  logic [2:0] cgb_sel;  // Logical CGB select
  logic       rc_wr;
  logic       cgb_wr;
  logic       rc_rd;
  logic       cgb_rd;

  // Decode of the accepted user cycle
  assign rc_wr  = uif_go && (uif_mode == UIF_MODE_WR) && (uif_addr == UIF_OFS_RC_SEL);
  assign cgb_wr = uif_go && (uif_mode == UIF_MODE_WR) && (uif_addr == UIF_OFS_CGB_SEL);
  assign rc_rd  = uif_go && (uif_mode == UIF_MODE_RD) && (uif_addr == UIF_OFS_RC_PHYS);
  assign cgb_rd = uif_go && (uif_mode == UIF_MODE_RD) && (uif_addr == UIF_OFS_CGB_PHYS);

  assign l2p_read      = rc_rd || cgb_rd;  // ROM fetch only, no RMW
  assign logical_index = (kind == SW_CGB) ? cgb_sel : rc_sel;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rc_sel  <= 3'd0;
      cgb_sel <= 3'd0;
      kind    <= SW_REFCLK;
      start   <= 1'b0;
    end else begin
      start <= rc_wr || cgb_wr;  // Delayed so the select is already stored
      if (rc_wr)
        rc_sel <= uif_wdata[2:0];
      if (cgb_wr)
        cgb_sel <= uif_wdata[2:0];
      if (rc_wr || rc_rd)
        kind <= SW_REFCLK;
      else if (cgb_wr || cgb_rd)
        kind <= SW_CGB;
    end
  end

  // Readback, any read-mode cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      uif_rdata    <= '0;
      uif_addr_err <= 1'b0;
    end else begin
      uif_addr_err <= (uif_addr > UIF_OFS_LAST);
      if (uif_mode == UIF_MODE_RD) begin
        case (uif_addr)
          UIF_OFS_RC_SEL:   uif_rdata <= UIF_DATA_W'(rc_sel);
          UIF_OFS_CGB_SEL:  uif_rdata <= UIF_DATA_W'(cgb_sel);
          UIF_OFS_RC_PHYS:  uif_rdata <= UIF_DATA_W'(phys_refclk_word); // Five refclk IDs
          UIF_OFS_CGB_PHYS: uif_rdata <= UIF_DATA_W'(phys_cgb_word);    // Five CGB IDs
          default:          uif_rdata <= '0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/pll_reconfig_rmw.sv
`timescale 1ns/1ps
`default_nettype none

module pll_reconfig_rmw import pll_reconfig_pkg::*; (
  input  wire                     clk,
  input  wire                     reset,
  input  var switch_kind_t        kind,
  input  wire [1:0]               word_cnt,
  input  wire                     capture,
  input  wire [CTRL_DATA_W-1:0]   ctrl_rdata,
  input  wire [9:0]               cgb_bits,
  input  wire [9:0]               cdr_bits,
  output logic [15:0]             merge_data,
  output logic [CTRL_ADDR_W-1:0]  word_addr
);

  logic [15:0] saved_data;  // Word from the last DPRIO read

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      saved_data <= 16'd0;
    else if (capture)
      saved_data <= ctrl_rdata[15:0];
  end

  // Merge new select bits, keep the rest of the word
  always_comb begin
    if (kind == SW_CGB) begin
      merge_data = {cgb_bits[9:8], saved_data[13:9], cgb_bits[7:0], saved_data[0]};
      word_addr  = DPRIO_CGB_OFS;
    end else begin
      case (word_cnt)
        2'd2: begin  // pcie_mode into bit 6
          merge_data = {saved_data[15:7], cdr_bits[8], saved_data[5:0]};
          word_addr  = DPRIO_PCIEMD_OFS;
        end
        2'd1: begin
          merge_data = {cdr_bits[9], saved_data[14:0]};  // rrefclk_sel, bit 15
          word_addr  = DPRIO_RREF_OFS;
        end
        default: begin  // Last word, iq_clk_sel into 10:3
          merge_data = {saved_data[15:11], cdr_bits[7:0], saved_data[2:0]};
          word_addr  = DPRIO_REFIQ_OFS;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the regression with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module pll_reconfig_tb -o sim_pll_reconfig
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

./obj_dir/sim_pll_reconfig > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Regression failed" sim.log; then
  exit 1
fi
exit 0

// File: tests/basic_block_model.sv
`timescale 1ns/1ps
`default_nettype none

module basic_block_model import pll_reconfig_pkg::*; (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     ctrl_go,
  input  wire [2:0]               ctrl_opcode,
  input  wire                     ctrl_lock,
  input  wire [CTRL_ADDR_W-1:0]   ctrl_addr,
  input  wire [CTRL_DATA_W-1:0]   ctrl_wdata,
  output logic                    ctrl_wait,
  output logic [CTRL_DATA_W-1:0]  ctrl_rdata
);

  logic [15:0]            dprio_mem [0:4095];  // DPRIO word space
  logic [31:0]            lfsr;
  logic [1:0]             wait_cnt;
  logic [2:0]             op_q;
  logic [CTRL_ADDR_W-1:0] addr_q;
  logic [CTRL_DATA_W-1:0] wdata_q;
  int                     go_cnt;
  int                     lock_cnt;   // Accesses that saw ctrl_lock high
  int                     wr_cnt;

  // Fibonacci taps 32, 22, 2, 1
  function automatic logic [31:0] step_lfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // L2P ROM, refclk IDs 9,24,22,14,3 and CGB IDs 7,6,3,0,9 from slot 4 down
  function automatic logic [31:0] rom_word(input logic [CTRL_ADDR_W-1:0] a);
    case (a)
      ROM_WORD_RC:  return 32'h009C_59C3;
      ROM_WORD_CGB: return 32'h0007_6309;
      default:      return 32'h0000_0000;
    endcase
  endfunction

  initial begin
    go_cnt   = 0;
    lock_cnt = 0;
    wr_cnt   = 0;
    lfsr     = 32'h1d6fc10b;
    for (int a = 0; a < 4096; a++) begin
      for (int b = 0; b < 16; b++) begin
        lfsr = step_lfsr(lfsr);
        dprio_mem[a][b] = lfsr[0];  // One step per bit
      end
    end
  end

  //////////////////////////////
  // Access engine
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      ctrl_wait  <= 1'b0;
      ctrl_rdata <= '0;
      wait_cnt   <= 2'd0;
    end else if (ctrl_go) begin
      go_cnt   = go_cnt + 1;
      lock_cnt = lock_cnt + int'(ctrl_lock);
      op_q    <= ctrl_opcode;
      addr_q  <= ctrl_addr;
      wdata_q <= ctrl_wdata;
      lfsr = step_lfsr(lfsr);
      wait_cnt[0] <= lfsr[0];
      lfsr = step_lfsr(lfsr);
      wait_cnt[1] <= lfsr[0];
      ctrl_wait   <= 1'b1;  // Raised on the go edge
    end else if (ctrl_wait) begin
      if (wait_cnt == 2'd0) begin  // Last busy cycle
        ctrl_wait <= 1'b0;
        case (op_q)
          CTRL_OP_ROM_RD: ctrl_rdata <= rom_word(addr_q);
          CTRL_OP_RD:     ctrl_rdata <= {16'h0000, dprio_mem[addr_q]};
          CTRL_OP_WR: begin
            dprio_mem[addr_q] <= wdata_q[15:0];
            wr_cnt = wr_cnt + 1;
          end
          default:        ctrl_rdata <= '0;
        endcase
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/pll_reconfig_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module pll_reconfig_asserts (
  input wire       clk,
  input wire       reset,
  input wire       ctrl_go,
  input wire [2:0] ctrl_opcode,
  input wire       ctrl_wait,
  input wire       uif_busy
);

  int fail_cnt = 0;  // Failed assertions so far

  // One pulse per access
  go_single: assert property (@(posedge clk) disable iff (reset) ctrl_go |=> !ctrl_go)
    else begin
      $error("ctrl_go was high two cycles in a row");
      fail_cnt++;
    end

  // Opcode held while the basic block works
  opcode_hold: assert property (@(posedge clk) disable iff (reset)
    ctrl_wait |-> $stable(ctrl_opcode))
    else begin
      $error("ctrl_opcode changed while ctrl_wait was high");
      fail_cnt++;
    end

  busy_in_reset: assert property (@(posedge clk) reset |-> !uif_busy)
    else begin
      $error("uif_busy high during reset");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// File: tests/pll_reconfig_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pll_reconfig_tb import pll_reconfig_pkg::*; ();

  typedef enum logic [1:0] {ROW_RD, ROW_WR, ROW_L2P} row_op_t;

  logic        clk;
  logic        reset;
  logic        uif_go;
  logic [2:0]  uif_mode;
  logic [2:0]  uif_addr;
  logic [31:0] uif_wdata;
  logic [9:0]  uif_logical_ch_addr;
  logic [31:0] uif_rdata;
  logic        uif_busy;
  logic        uif_addr_err;
  logic        ctrl_go;
  logic [2:0]  ctrl_opcode;
  logic        ctrl_lock;
  logic        ctrl_wait;
  logic [9:0]  ctrl_lch;
  logic [11:0] ctrl_addr;
  logic [31:0] ctrl_rdata;
  logic [31:0] ctrl_wdata;

  logic [15:0] shadow [0:4095];  // Expected DPRIO contents
  string       names[$];
  row_op_t     ops[$];
  logic [2:0]  ofs_q[$];
  logic [31:0] data_q[$];
  logic [31:0] exp_q[$];         // Expected rdata
  logic        err_q[$];
  logic [1:0]  x_q[$];           // CGB x_en, or {pcie_mode, rrefclk_sel}
  logic [7:0]  sel_q[$];         // clk_sel or iq_clk_sel
  int          errors;

  pll_reconfig_ctrl pll_reconfig_ctrl_inst (.*);

  basic_block_model basic_block_model_inst (
    .clk, .reset, .ctrl_go, .ctrl_opcode, .ctrl_lock, .ctrl_addr, .ctrl_wdata,
    .ctrl_wait, .ctrl_rdata
  );

  bind pll_reconfig_fsm pll_reconfig_asserts asserts_inst (
    .clk(clk), .reset(reset), .ctrl_go(ctrl_go), .ctrl_opcode(ctrl_opcode),
    .ctrl_wait(ctrl_wait), .uif_busy(uif_busy)
  );

  always #4 clk = ~clk;

  initial begin
    #2000000;
    $display("timeout: simulation ran past its time limit");
    $display("Regression failed");
    $finish;
  end

  function automatic logic [31:0] step_lfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic add_row(input string n, input row_op_t op, input logic [2:0] ofs,
                         input logic [31:0] d, input logic [31:0] e, input logic er,
                         input logic [1:0] x, input logic [7:0] sel);
    names.push_back(n);
    ops.push_back(op);
    ofs_q.push_back(ofs);
    data_q.push_back(d);
    exp_q.push_back(e);
    err_q.push_back(er);
    x_q.push_back(x);
    sel_q.push_back(sel);
  endtask

  task automatic check_value(input string n, input logic [31:0] e, input logic [31:0] g);
    assert (g === e) else begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", n, e, g);
    end
  endtask

  task automatic read_reg(input logic [2:0] a, output logic [31:0] d, output logic er);
    @(posedge clk);
    #1;
    uif_go   = 1'b1;
    uif_mode = UIF_MODE_RD;
    uif_addr = a;
    @(posedge clk);
    #1;
    uif_go = 1'b0;
    d  = uif_rdata;  // Registered on the go edge
    er = uif_addr_err;
  endtask

  task automatic write_reg(input logic [2:0] a, input logic [31:0] d);
    @(posedge clk);
    #1;
    uif_go    = 1'b1;
    uif_mode  = UIF_MODE_WR;
    uif_addr  = a;
    uif_wdata = d;
    @(posedge clk);
    #1;
    uif_go = 1'b0;
  endtask

  // Busy rise then fall, both bounded
  task automatic wait_idle(input string n);
    int k;
    k = 0;
    while (!uif_busy && k < 16) begin
      @(posedge clk);
      #1;
      k++;
    end
    assert (uif_busy) else begin
      errors++;
      $display("%s: uif_busy never went high", n);
    end
    k = 0;
    while (uif_busy && k < 500) begin
      @(posedge clk);
      #1;
      k++;
    end
    assert (!uif_busy) else begin
      errors++;
      $display("%s: timed out waiting for uif_busy to fall", n);
    end
  endtask

  task automatic check_dprio(input string n);
    logic [11:0] a;
    for (int k = 0; k < 4; k++) begin
      a = (k == 0) ? DPRIO_CGB_OFS : (k == 1) ? DPRIO_REFIQ_OFS :
          (k == 2) ? DPRIO_RREF_OFS : DPRIO_PCIEMD_OFS;
      check_value($sformatf("%s_dprio_%h", n, a), {16'h0, shadow[a]},
                  {16'h0, basic_block_model_inst.dprio_mem[a]});
    end
  endtask

  initial begin
    logic [31:0] lf;
    logic [31:0] got;
    logic        er;
    int          go0;
    int          lock0;
    int          wr0;
    int          n_go;
    int          assert_fails;
    clk = 1'b0;
    reset = 1'b1;
    uif_go = 1'b0;
    uif_mode = UIF_MODE_RD;
    uif_addr = 3'd0;
    uif_wdata = 32'd0;
    uif_logical_ch_addr = 10'h15A;
    errors = 0;
    lf = 32'h1d6fc10b;
    for (int a = 0; a < 4096; a++) begin  // Same fill as the model
      for (int b = 0; b < 16; b++) begin
        lf = step_lfsr(lf);
        shadow[a][b] = lf[0];
      end
    end

    //////////////////////////////
    // Stimulus table
    add_row("reset_rd0", ROW_RD,  3'd0, 32'd0, 32'd0, 1'b0, 2'd0, 8'h00);
    add_row("l2p_rc",    ROW_L2P, 3'd2, 32'd0, 32'h009C59C3, 1'b0, 2'd0, 8'h00);
    add_row("l2p_cgb",   ROW_L2P, 3'd3, 32'd0, 32'h00076309, 1'b0, 2'd0, 8'h00);
    add_row("rc_sel_0",  ROW_WR,  3'd0, 32'd0, 32'd0, 1'b0, 2'b00, 8'h04);  // ID 3
    add_row("rc_sel_1",  ROW_WR,  3'd0, 32'd1, 32'd1, 1'b0, 2'b00, 8'h40);  // ID 14
    add_row("rc_sel_2",  ROW_WR,  3'd0, 32'hFFFFFFFA, 32'd2, 1'b0, 2'b01, 8'h00); // PLD clk
    add_row("rc_sel_3",  ROW_WR,  3'd0, 32'd3, 32'd3, 1'b0, 2'b00, 8'h0C);  // FFPLL top
    add_row("rc_sel_4",  ROW_WR,  3'd0, 32'd4, 32'd4, 1'b0, 2'b00, 8'h0A);  // ID 9
    add_row("rc_sel_6",  ROW_WR,  3'd0, 32'd6, 32'd6, 1'b0, 2'b00, 8'h04);  // Slot 0
    add_row("cgb_sel_0", ROW_WR,  3'd1, 32'd0, 32'd0, 1'b0, 2'b00, 8'h18);  // XN down
    add_row("cgb_sel_1", ROW_WR,  3'd1, 32'd1, 32'd1, 1'b0, 2'b00, 8'h5C);  // Local PLL
    add_row("cgb_sel_2", ROW_WR,  3'd1, 32'd2, 32'd2, 1'b0, 2'b00, 8'hA0);  // LC top
    add_row("cgb_sel_3", ROW_WR,  3'd1, 32'd3, 32'd3, 1'b0, 2'b10, 8'h18);  // X6 up
    add_row("cgb_sel_4", ROW_WR,  3'd1, 32'd4, 32'd4, 1'b0, 2'b01, 8'h14);  // X6 down
    add_row("rd_ofs4",   ROW_RD,  3'd4, 32'd0, 32'd0, 1'b1, 2'd0, 8'h00);
    add_row("rd_ofs7",   ROW_RD,  3'd7, 32'd0, 32'd0, 1'b1, 2'd0, 8'h00);
    add_row("rd_ofs1",   ROW_RD,  3'd1, 32'd0, 32'd4, 1'b0, 2'd0, 8'h00);

    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    check_value("reset_busy", 32'd0, {31'd0, uif_busy});
    check_value("reset_go", 32'd0, {31'd0, ctrl_go});
    check_value("reset_lock", 32'd0, {31'd0, ctrl_lock});
    check_value("reset_opcode", 32'd0, {29'd0, ctrl_opcode});
    check_value("reset_addr", 32'd0, {20'd0, ctrl_addr});
    check_value("reset_wdata", 32'd0, ctrl_wdata);
    check_value("reset_rdata", 32'd0, uif_rdata);
    check_value("lch", {22'd0, uif_logical_ch_addr}, {22'd0, ctrl_lch});

    foreach (names[i]) begin
      go0   = basic_block_model_inst.go_cnt;
      lock0 = basic_block_model_inst.lock_cnt;
      wr0   = basic_block_model_inst.wr_cnt;
      case (ops[i])
        ROW_RD: begin
          read_reg(ofs_q[i], got, er);
          check_value(names[i], exp_q[i], got);
          check_value({names[i], "_err"}, {31'd0, err_q[i]}, {31'd0, er});
        end
        ROW_L2P: begin
          read_reg(ofs_q[i], got, er);
          wait_idle(names[i]);
          read_reg(ofs_q[i], got, er);
          wait_idle(names[i]);  // Second read fetches the ROM word again
          check_value(names[i], exp_q[i], got);
          check_value({names[i], "_go"}, 32'd2, basic_block_model_inst.go_cnt - go0);
          check_value({names[i], "_lock"}, 32'd0, basic_block_model_inst.lock_cnt - lock0);
          check_value({names[i], "_wr"}, 32'd0, basic_block_model_inst.wr_cnt - wr0);
          check_dprio(names[i]);
        end
        default: begin
          if (ofs_q[i] == UIF_OFS_CGB_SEL) begin  // One RMW word
            shadow[DPRIO_CGB_OFS] = (shadow[DPRIO_CGB_OFS] & ~16'hC1FE) |
                                    {x_q[i], 5'd0, sel_q[i], 1'b0};
            n_go = 3;
          end else begin  // Three RMW words
            shadow[DPRIO_PCIEMD_OFS][6] = x_q[i][1];
            shadow[DPRIO_RREF_OFS][15]  = x_q[i][0];
            shadow[DPRIO_REFIQ_OFS] = (shadow[DPRIO_REFIQ_OFS] & ~16'h07F8) |
                                      {5'd0, sel_q[i], 3'd0};
            n_go = 7;
          end
          write_reg(ofs_q[i], data_q[i]);
          wait_idle(names[i]);
          check_dprio(names[i]);
          check_value({names[i], "_go"}, n_go, basic_block_model_inst.go_cnt - go0);
          check_value({names[i], "_lock"}, n_go, basic_block_model_inst.lock_cnt - lock0);
          check_value({names[i], "_wr"}, (n_go - 1) / 2, basic_block_model_inst.wr_cnt - wr0);
          read_reg(ofs_q[i], got, er);
          check_value({names[i], "_readback"}, exp_q[i], got);
        end
      endcase
    end

    assert_fails = pll_reconfig_ctrl_inst.pll_reconfig_fsm_inst.asserts_inst.fail_cnt;
    $display("Closing: %0d check errors, %0d assertion failures, %0d table rows",
             errors, assert_fails, names.size());
    if (errors == 0 && assert_fails == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire
